/* logic/core_pkg.sv */
// Shared definitions for the rs5 integer core.
// Widths, RV32I opcode and funct fields, the operation encoding and the
// structs that carry an instruction between pipeline stages.
`default_nettype none

package core_pkg;

    localparam int unsigned xlen       = 32;
    localparam int unsigned reg_addr_w = 5;
    localparam int unsigned num_regs   = 32;
    localparam int unsigned strb_w     = xlen / 8;  // One write enable per byte lane.

    localparam logic [xlen-1:0] reset_pc = '0;
    localparam logic [xlen-1:0] pc_step  = 32'd4;

    // Major opcodes of the kept instruction classes.
    localparam logic [6:0] opcode_op     = 7'b0110011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;
    localparam logic [6:0] opcode_lui    = 7'b0110111;
    localparam logic [6:0] opcode_store  = 7'b0100011;

    // ALU subcodes, shared by the register and immediate forms.
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // Store widths.
    localparam logic [2:0] f3_sb = 3'b000;
    localparam logic [2:0] f3_sh = 3'b001;
    localparam logic [2:0] f3_sw = 3'b010;

    localparam logic [6:0] funct7_base = 7'b0000000;
    localparam logic [6:0] funct7_alt  = 7'b0100000;  // Selects SUB and SRA.

    typedef enum logic [7:0] {
        NOP, ADD, SUB, SLT, SLTU, XOR, OR, AND,
        SLL, SRL, SRA, LUI, SB, SH, SW
    } instr_op_e;

    // Decode to execute.
    typedef struct packed {
        logic                  valid;
        instr_op_e             op;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       operand_a;
        logic [xlen-1:0]       operand_b;   // Register value or immediate.
        logic [xlen-1:0]       store_data;
    } decoded_t;

    // Execute to retire.
    typedef struct packed {
        logic                  valid;
        instr_op_e             op;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       result;      // Byte address for stores.
        logic [xlen-1:0]       store_data;
    } exec_result_t;

    // A register write, seen by the bypass and by the register bank.
    typedef struct packed {
        logic                  we;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       value;
    } fwd_t;

endpackage

`default_nettype wire

/* logic/fetch.sv */
// Fetch stage of the rs5 core.
// Holds the program counter that addresses the instruction memory.
`timescale 1ns/10ps
`default_nettype none

module fetch (
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire logic                     stall_i,
    output logic [core_pkg::xlen-1:0]     pc_o
);

    logic [core_pkg::xlen-1:0] pc_next;

    // Straight-line code only, so the next address is always one step on.
    assign pc_next = pc_o + core_pkg::pc_step;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_o <= core_pkg::reset_pc;
        end else if (!stall_i) begin
            pc_o <= pc_next;       // Held while the core is stalled.
        end
    end

endmodule

`default_nettype wire

/* logic/decode.sv */
// Decode stage and pipeline control of the rs5 core.
// Maps instruction fields to an operation, builds immediates, resolves the
// source operands through the bypass paths and registers the result.
`timescale 1ns/10ps
`default_nettype none

module decode (
    input  wire logic                           clk,
    input  wire logic                           reset,
    input  wire logic                           stall_i,
    input  wire logic [core_pkg::xlen-1:0]      instruction_i,
    output logic [core_pkg::reg_addr_w-1:0]     rs1_o,
    output logic [core_pkg::reg_addr_w-1:0]     rs2_o,
    input  wire logic [core_pkg::xlen-1:0]      rs1_data_i,
    input  wire logic [core_pkg::xlen-1:0]      rs2_data_i,
    input  wire core_pkg::fwd_t                 exec_fwd_i,
    input  wire core_pkg::fwd_t                 wb_fwd_i,
    output core_pkg::decoded_t                  decoded_o
);

    logic [6:0]                opcode;
    logic [2:0]                funct3;
    logic [6:0]                funct7;
    logic [core_pkg::xlen-1:0] imm_i;
    logic [core_pkg::xlen-1:0] imm_s;
    logic [core_pkg::xlen-1:0] imm_u;
    logic [core_pkg::xlen-1:0] rs1_val;
    logic [core_pkg::xlen-1:0] rs2_val;
    logic [core_pkg::xlen-1:0] operand_b;
    core_pkg::instr_op_e       op;
    core_pkg::decoded_t        decoded_d;

    // Youngest producer wins. x0 is never forwarded.
    function automatic logic [core_pkg::xlen-1:0] resolve(
        input logic [core_pkg::reg_addr_w-1:0] idx,
        input logic [core_pkg::xlen-1:0]       bank_val,
        input core_pkg::fwd_t                  ex,
        input core_pkg::fwd_t                  wb
    );
        if (idx == '0) begin
            return '0;
        end
        if (ex.we && ex.rd == idx) begin
            return ex.value;
        end
        if (wb.we && wb.rd == idx) begin
            return wb.value;
        end
        return bank_val;
    endfunction

    assign opcode = instruction_i[6:0];
    assign funct3 = instruction_i[14:12];
    assign funct7 = instruction_i[31:25];
    assign rs1_o  = instruction_i[19:15];
    assign rs2_o  = instruction_i[24:20];

    assign imm_i = {{20{instruction_i[31]}}, instruction_i[31:20]};
    assign imm_s = {{20{instruction_i[31]}}, instruction_i[31:25], instruction_i[11:7]};
    assign imm_u = {instruction_i[31:12], 12'b0};

    assign rs1_val = resolve(rs1_o, rs1_data_i, exec_fwd_i, wb_fwd_i);
    assign rs2_val = resolve(rs2_o, rs2_data_i, exec_fwd_i, wb_fwd_i);

    // Anything not listed decodes as a bubble.
    always_comb begin
        op = core_pkg::NOP;
        case (opcode)
            core_pkg::opcode_op: begin
                if (funct7 == core_pkg::funct7_base) begin
                    case (funct3)
                        core_pkg::f3_add_sub: op = core_pkg::ADD;
                        core_pkg::f3_sll:     op = core_pkg::SLL;
                        core_pkg::f3_slt:     op = core_pkg::SLT;
                        core_pkg::f3_sltu:    op = core_pkg::SLTU;
                        core_pkg::f3_xor:     op = core_pkg::XOR;
                        core_pkg::f3_srl_sra: op = core_pkg::SRL;
                        core_pkg::f3_or:      op = core_pkg::OR;
                        default:              op = core_pkg::AND;
                    endcase
                end else if (funct7 == core_pkg::funct7_alt) begin
                    if (funct3 == core_pkg::f3_add_sub) begin
                        op = core_pkg::SUB;
                    end else if (funct3 == core_pkg::f3_srl_sra) begin
                        op = core_pkg::SRA;
                    end
                end
            end
            core_pkg::opcode_op_imm: begin
                case (funct3)
                    core_pkg::f3_add_sub: op = core_pkg::ADD;    // No SUBI in RV32I.
                    core_pkg::f3_slt:     op = core_pkg::SLT;
                    core_pkg::f3_sltu:    op = core_pkg::SLTU;
                    core_pkg::f3_xor:     op = core_pkg::XOR;
                    core_pkg::f3_or:      op = core_pkg::OR;
                    core_pkg::f3_and:     op = core_pkg::AND;
                    core_pkg::f3_sll: begin
                        if (funct7 == core_pkg::funct7_base) begin
                            op = core_pkg::SLL;
                        end
                    end
                    default: begin
                        if (funct7 == core_pkg::funct7_base) begin
                            op = core_pkg::SRL;
                        end else if (funct7 == core_pkg::funct7_alt) begin
                            op = core_pkg::SRA;
                        end
                    end
                endcase
            end
            core_pkg::opcode_lui: op = core_pkg::LUI;
            core_pkg::opcode_store: begin
                case (funct3)
                    core_pkg::f3_sb: op = core_pkg::SB;
                    core_pkg::f3_sh: op = core_pkg::SH;
                    core_pkg::f3_sw: op = core_pkg::SW;
                    default:         op = core_pkg::NOP;
                endcase
            end
            default: op = core_pkg::NOP;
        endcase
    end

    // Second operand source per instruction class.
    always_comb begin
        case (opcode)
            core_pkg::opcode_op_imm: operand_b = imm_i;
            core_pkg::opcode_store:  operand_b = imm_s;     // Address offset.
            core_pkg::opcode_lui:    operand_b = imm_u;
            default:                 operand_b = rs2_val;
        endcase
    end

    always_comb begin
        decoded_d.valid      = (op != core_pkg::NOP);
        decoded_d.op         = op;
        decoded_d.rd         = instruction_i[11:7];
        decoded_d.operand_a  = rs1_val;
        decoded_d.operand_b  = operand_b;
        decoded_d.store_data = rs2_val;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            decoded_o.valid <= 1'b0;
        end else if (!stall_i) begin
            decoded_o <= decoded_d;
        end
    end

endmodule

`default_nettype wire

/* logic/regbank.sv */
// Integer register file of the rs5 core.
// Two combinational read ports and one write port, x0 hardwired to zero.
`timescale 1ns/10ps
`default_nettype none

module regbank (
    input  wire logic                           clk,
    input  wire logic                           reset,
    input  wire logic [core_pkg::reg_addr_w-1:0] rs1_i,
    input  wire logic [core_pkg::reg_addr_w-1:0] rs2_i,
    input  wire core_pkg::fwd_t                 wb_i,
    output logic [core_pkg::xlen-1:0]           rs1_data_o,
    output logic [core_pkg::xlen-1:0]           rs2_data_o
);

    logic [core_pkg::xlen-1:0] regs [core_pkg::num_regs];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < core_pkg::num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.we) begin
            regs[wb_i.rd] <= wb_i.value;
        end
    end

    // A write lands only at the edge, so same-cycle readers go through the bypass.
    assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire

/* logic/execute.sv */
// Execute stage of the rs5 core.
// Adder, logic and shift units, store address generation and the
// register that feeds retire.
`timescale 1ns/10ps
`default_nettype none

module execute (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               stall_i,
    input  wire core_pkg::decoded_t decoded_i,
    output core_pkg::fwd_t          exec_fwd_o,
    output core_pkg::exec_result_t  result_o
);

    logic [core_pkg::xlen-1:0] a;
    logic [core_pkg::xlen-1:0] b;
    logic [core_pkg::xlen-1:0] sum;
    logic [core_pkg::xlen:0]   diff;        // Extra bit holds the unsigned borrow.
    logic                      lt_signed;
    logic [4:0]                shamt;
    logic [core_pkg::xlen-1:0] alu_out;
    logic                      is_store;

    assign a     = decoded_i.operand_a;
    assign b     = decoded_i.operand_b;
    assign shamt = b[4:0];

    assign sum  = a + b;
    assign diff = {1'b0, a} - {1'b0, b};
    // Signs differ, so the negative one is smaller.
    assign lt_signed = (a[core_pkg::xlen-1] != b[core_pkg::xlen-1]) ?
                       a[core_pkg::xlen-1] : diff[core_pkg::xlen-1];

    always_comb begin
        case (decoded_i.op)
            core_pkg::ADD:  alu_out = sum;
            core_pkg::SUB:  alu_out = diff[core_pkg::xlen-1:0];
            core_pkg::SLT:  alu_out = {31'b0, lt_signed};
            core_pkg::SLTU: alu_out = {31'b0, diff[core_pkg::xlen]};
            core_pkg::XOR:  alu_out = a ^ b;
            core_pkg::OR:   alu_out = a | b;
            core_pkg::AND:  alu_out = a & b;
            core_pkg::SLL:  alu_out = a << shamt;
            core_pkg::SRL:  alu_out = a >> shamt;
            core_pkg::SRA:  alu_out = $signed(a) >>> shamt;
            core_pkg::LUI:  alu_out = b;
            core_pkg::SB, core_pkg::SH, core_pkg::SW: alu_out = sum;  // Byte address.
            default:        alu_out = '0;
        endcase
    end

    assign is_store = decoded_i.op inside {core_pkg::SB, core_pkg::SH, core_pkg::SW};

    // Bypass to decode for the instruction right behind this one.
    assign exec_fwd_o.we    = decoded_i.valid && !is_store && (decoded_i.rd != '0);
    assign exec_fwd_o.rd    = decoded_i.rd;
    assign exec_fwd_o.value = alu_out;

    always_ff @(posedge clk) begin
        if (reset) begin
            result_o.valid <= 1'b0;
        end else if (!stall_i) begin
            result_o.valid      <= decoded_i.valid;
            result_o.op         <= decoded_i.op;
            result_o.rd         <= decoded_i.rd;
            result_o.result     <= alu_out;
            result_o.store_data <= decoded_i.store_data;
        end
    end

endmodule

`default_nettype wire

/* logic/retire.sv */
// Retire stage of the rs5 core.
// Register writeback and store lane steering onto the data memory port.
`timescale 1ns/10ps
`default_nettype none

module retire (
    input  wire logic                       stall_i,
    input  wire core_pkg::exec_result_t     result_i,
    output core_pkg::fwd_t                  wb_o,
    output logic                            mem_operation_enable_o,
    output logic [core_pkg::strb_w-1:0]     mem_write_enable_o,
    output logic [core_pkg::xlen-1:0]       mem_address_o,
    output logic [core_pkg::xlen-1:0]       mem_data_o
);

    logic                        is_store;
    logic [core_pkg::strb_w-1:0] byte_en;
    logic [1:0]                  offset;

    assign is_store = result_i.valid &&
                      (result_i.op inside {core_pkg::SB, core_pkg::SH, core_pkg::SW});
    assign offset   = result_i.result[1:0];

    // Nothing commits while stalled; the entry waits for the next free cycle.
    assign wb_o.we    = !stall_i && result_i.valid && !is_store && (result_i.rd != '0);
    assign wb_o.rd    = result_i.rd;
    assign wb_o.value = result_i.result;

    always_comb begin
        case (result_i.op)
            core_pkg::SB: begin
                byte_en    = 4'b0001 << offset;
                mem_data_o = {4{result_i.store_data[7:0]}};
            end
            core_pkg::SH: begin
                byte_en    = offset[1] ? 4'b1100 : 4'b0011;
                mem_data_o = {2{result_i.store_data[15:0]}};
            end
            default: begin
                byte_en    = 4'b1111;             // SW, or masked below.
                mem_data_o = result_i.store_data;
            end
        endcase
    end

    assign mem_write_enable_o     = (is_store && !stall_i) ? byte_en : '0;
    assign mem_operation_enable_o = |mem_write_enable_o;
    assign mem_address_o          = {result_i.result[core_pkg::xlen-1:2], 2'b00};

endmodule

`default_nettype wire

/* logic/rs5_core.sv */
// Top level of the rs5 three-stage RV32I integer core.
// Connects fetch, decode, the register bank, execute and retire.
`timescale 1ns/10ps
`default_nettype none

module rs5_core (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       stall_i,
    input  wire logic [core_pkg::xlen-1:0]  instruction_i,
    output logic [core_pkg::xlen-1:0]       instruction_address_o,
    output logic                            mem_operation_enable_o,
    output logic [core_pkg::strb_w-1:0]     mem_write_enable_o,
    output logic [core_pkg::xlen-1:0]       mem_address_o,
    output logic [core_pkg::xlen-1:0]       mem_data_o
);

    logic [core_pkg::reg_addr_w-1:0] rs1;
    logic [core_pkg::reg_addr_w-1:0] rs2;
    logic [core_pkg::xlen-1:0]       rs1_data;
    logic [core_pkg::xlen-1:0]       rs2_data;
    core_pkg::decoded_t              decoded;
    core_pkg::exec_result_t          exec_result;
    core_pkg::fwd_t                  exec_fwd;     // Distance-one bypass.
    core_pkg::fwd_t                  wb_fwd;       // Writeback and distance-two bypass.

    fetch u_fetch (
        .clk        (clk),
        .reset      (reset),
        .stall_i    (stall_i),
        .pc_o       (instruction_address_o)
    );

    decode u_decode (
        .clk            (clk),
        .reset          (reset),
        .stall_i        (stall_i),
        .instruction_i  (instruction_i),
        .rs1_o          (rs1),
        .rs2_o          (rs2),
        .rs1_data_i     (rs1_data),
        .rs2_data_i     (rs2_data),
        .exec_fwd_i     (exec_fwd),
        .wb_fwd_i       (wb_fwd),
        .decoded_o      (decoded)
    );

    regbank u_regbank (
        .clk        (clk),
        .reset      (reset),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .wb_i       (wb_fwd),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    execute u_execute (
        .clk        (clk),
        .reset      (reset),
        .stall_i    (stall_i),
        .decoded_i  (decoded),
        .exec_fwd_o (exec_fwd),
        .result_o   (exec_result)
    );

    retire u_retire (
        .stall_i                (stall_i),
        .result_i               (exec_result),
        .wb_o                   (wb_fwd),
        .mem_operation_enable_o (mem_operation_enable_o),
        .mem_write_enable_o     (mem_write_enable_o),
        .mem_address_o          (mem_address_o),
        .mem_data_o             (mem_data_o)
    );

endmodule

`default_nettype wire

/* tb/core_assertions.sv */
// Concurrent checks on the data memory port of the rs5 core.
`timescale 1ns/10ps
`default_nettype none

module core_assertions (
    input wire logic                        clk,
    input wire logic                        reset,
    input wire logic                        mem_operation_enable_i,
    input wire logic [core_pkg::strb_w-1:0] mem_write_enable_i,
    input wire logic [core_pkg::xlen-1:0]   mem_address_i
);

    int unsigned fail_count = 0;

    enable_sets_operation: assert property (@(posedge clk) disable iff (reset)
        (mem_write_enable_i != '0) |-> mem_operation_enable_i)
        else begin
            $error("write enable set without mem_operation_enable_o");
            fail_count = fail_count + 1;
        end

    word_aligned_address: assert property (@(posedge clk) disable iff (reset)
        mem_address_i[1:0] == 2'b00)
        else begin
            $error("mem_address_o is not word aligned");
            fail_count = fail_count + 1;
        end

    // Idle, SB lanes, SH halves or a full word.
    legal_enables: assert property (@(posedge clk) disable iff (reset)
        mem_write_enable_i inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                   4'b0011, 4'b1100, 4'b1111})
        else begin
            $error("illegal byte enable pattern");
            fail_count = fail_count + 1;
        end

    quiet_after_reset: assert property (@(posedge clk)
        reset |=> (mem_write_enable_i == '0))
        else begin
            $error("write enable set right after reset");
            fail_count = fail_count + 1;
        end

endmodule

bind rs5_core core_assertions u_core_assertions (
    .clk                    (clk),
    .reset                  (reset),
    .mem_operation_enable_i (mem_operation_enable_o),
    .mem_write_enable_i     (mem_write_enable_o),
    .mem_address_i          (mem_address_o)
);

`default_nettype wire

/* tb/tb_core.sv */
// Testbench for the rs5 core.
// Random straight-line programs are checked against an ISA reference model
// at the store port, under random stalls.
`timescale 1ns/10ps
`default_nettype none

module tb_core;

    localparam int unsigned prog_len   = 400;
    localparam int unsigned seed       = 54343;
    localparam int unsigned clk_period = 100;
    localparam logic [31:0] nop_word   = {12'd0, 5'd0, core_pkg::f3_add_sub, 5'd0,
                                          core_pkg::opcode_op_imm};  // ADDI x0,x0,0.

    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  be;
        logic [31:0] data;
    } store_t;

    logic                              clk;
    logic                              reset;
    logic                              stall;
    logic [core_pkg::xlen-1:0]         instr;
    logic [core_pkg::xlen-1:0]         iaddr;
    logic                              mem_en;
    logic [core_pkg::strb_w-1:0]       mem_we;
    logic [core_pkg::xlen-1:0]         mem_addr;
    logic [core_pkg::xlen-1:0]         mem_data;

    logic [31:0]  prog [prog_len];
    logic [31:0]  model_regs [32] = '{default: '0};
    logic [4:0]   recent [3] = '{default: '0};     // Last three destinations.
    store_t       exp_q [$];
    logic [31:0]  lcg_state = seed;
    int unsigned  reset_edges = 0;
    int unsigned  quiet_cycles = 0;
    logic         pc_known = 1'b0;
    logic         prev_stall;
    logic [31:0]  prev_pc;

    rs5_core dut0 (
        .clk                    (clk),
        .reset                  (reset),
        .stall_i                (stall),
        .instruction_i          (instr),
        .instruction_address_o  (iaddr),
        .mem_operation_enable_o (mem_en),
        .mem_write_enable_o     (mem_we),
        .mem_address_o          (mem_addr),
        .mem_data_o             (mem_data)
    );

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {8'd0, lcg_state[31:8]};        // Low LCG bits are weak.
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        return next_rand() % n;
    endfunction

    function automatic logic [4:0] pick_source();
        if (rand_below(100) < 60) begin
            return recent[rand_below(3)];
        end
        return 5'(rand_below(32));
    endfunction

    // RV32I semantics of the ALU subcodes.
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            core_pkg::f3_add_sub: return alt ? a - b : a + b;
            core_pkg::f3_sll:     return a << b[4:0];
            core_pkg::f3_slt:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            core_pkg::f3_sltu:    return (a < b) ? 32'd1 : 32'd0;
            core_pkg::f3_xor:     return a ^ b;
            core_pkg::f3_srl_sra: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            core_pkg::f3_or:      return a | b;
            default:              return a & b;
        endcase
    endfunction

    // Word address, byte lanes and replicated data of one store.
    function automatic store_t store_entry(input logic [2:0] f3, input logic [31:0] addr,
                                           input logic [31:0] v);
        store_t s;
        s.addr = {addr[31:2], 2'b00};
        if (f3 == core_pkg::f3_sb) begin
            s.be   = 4'b0001 << addr[1:0];
            s.data = {4{v[7:0]}};
        end else if (f3 == core_pkg::f3_sh) begin
            s.be   = addr[1] ? 4'b1100 : 4'b0011;
            s.data = {2{v[15:0]}};
        end else begin
            s.be   = 4'b1111;
            s.data = v;
        end
        return s;
    endfunction

    // Generates the program and runs it through the model at the same time.
    task automatic build_program();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [31:0] result;
        logic [11:0] imm;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic        alt;
        int unsigned kind;
        for (int i = 0; i < prog_len; i++) begin
            kind = rand_below(100);
            rd   = 5'(rand_below(32));
            rs1  = pick_source();
            rs2  = pick_source();
            f3   = 3'(rand_below(8));
            alt  = (rand_below(2) == 1);
            a    = model_regs[rs1];
            b    = model_regs[rs2];
            if (kind < 30) begin
                f3  = f3 % 3;
                imm = 12'((next_rand() & 32'h7fc) - (a & ((32'd1 << f3) - 32'd1)));
                prog[i] = {imm[11:5], rs2, rs1, f3, imm[4:0], core_pkg::opcode_store};
                exp_q.push_back(store_entry(f3, a + {{20{imm[11]}}, imm}, b));
            end else begin
                if (kind < 40) begin
                    r       = next_rand();
                    prog[i] = {r[19:0], rd, core_pkg::opcode_lui};
                    result  = {r[19:0], 12'b0};
                end else if (kind < 70) begin
                    alt     = alt && (f3 == core_pkg::f3_add_sub || f3 == core_pkg::f3_srl_sra);
                    prog[i] = {alt ? core_pkg::funct7_alt : core_pkg::funct7_base, rs2, rs1,
                               f3, rd, core_pkg::opcode_op};
                    result  = alu_ref(f3, alt, a, b);
                end else begin
                    imm = 12'(next_rand());
                    alt = alt && (f3 == core_pkg::f3_srl_sra);
                    if (f3 == core_pkg::f3_sll || f3 == core_pkg::f3_srl_sra) begin
                        imm = {alt ? core_pkg::funct7_alt : core_pkg::funct7_base, imm[4:0]};
                    end
                    prog[i] = {imm, rs1, f3, rd, core_pkg::opcode_op_imm};
                    result  = alu_ref(f3, alt, a, {{20{imm[11]}}, imm});
                end
                if (rd != 5'd0) begin
                    model_regs[rd] = result;
                end
                recent[2] = recent[1];
                recent[1] = recent[0];
                recent[0] = rd;
            end
        end
    endtask

    function automatic logic [31:0] word_at(input logic [31:0] addr);
        if (addr[31:2] < prog_len) begin
            return prog[addr[31:2]];
        end
        return nop_word;
    endfunction

    task automatic report_mismatch(input string sig, input logic [31:0] want,
                                   input logic [31:0] got);
        $display("mismatch at %0t: %s expected %h, got %h", $time, sig, want, got);
        $display("Test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_error(input string what);
        $display("error at %0t: %s", $time, what);
        $display("Test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_store();
        store_t want;
        assert (mem_en == (mem_we != '0))
            else report_mismatch("mem_operation_enable_o", {31'd0, mem_we != '0},
                                 {31'd0, mem_en});
        assert (mem_addr[1:0] == 2'b00)
            else report_mismatch("mem_address_o[1:0]", 32'd0, {30'd0, mem_addr[1:0]});
        if (mem_we == '0) begin
            if (exp_q.size() == 0) begin
                quiet_cycles++;
            end
        end else begin
            assert (!stall) else report_error("store issued during a stalled cycle");
            assert (exp_q.size() > 0) else report_error("store issued beyond the program's stores");
            want = exp_q.pop_front();
            assert (mem_addr == want.addr)
                else report_mismatch("mem_address_o", want.addr, mem_addr);
            assert (mem_we == want.be)
                else report_mismatch("mem_write_enable_o", {28'd0, want.be}, {28'd0, mem_we});
            assert (mem_data == want.data)
                else report_mismatch("mem_data_o", want.data, mem_data);
        end
    endtask

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    initial begin : stimulus
        reset = 1'b1;
        stall = 1'b0;
        instr = nop_word;
        build_program();
        repeat (10) @(negedge clk);         // Ten rising edges in reset.
        reset = 1'b0;
        forever begin
            instr = word_at(iaddr);
            stall = (rand_below(100) < 20);
            @(negedge clk);
        end
    end

    // Samples the values that the rising edge sees.
    always @(posedge clk) begin : port_checks
        logic [31:0] pc_exp;
        assert (dut0.u_core_assertions.fail_count == 0)
            else report_error("a concurrent assertion on the memory port failed");
        if (reset) begin
            if (reset_edges > 0) begin
                assert (mem_we == '0)
                    else report_mismatch("mem_write_enable_o", 32'd0, {28'd0, mem_we});
                assert (!mem_en)
                    else report_mismatch("mem_operation_enable_o", 32'd0, {31'd0, mem_en});
            end
            reset_edges++;
            pc_known = 1'b0;
        end else begin
            pc_exp = pc_known ? prev_pc + (prev_stall ? 32'd0 : 32'd4) : core_pkg::reset_pc;
            assert (iaddr == pc_exp) else report_mismatch("instruction_address_o", pc_exp, iaddr);
            prev_pc    = iaddr;
            prev_stall = stall;
            pc_known   = 1'b1;
            check_store();
            if (quiet_cycles >= 10) begin
                $display("Test completed successfully");
                $finish;
            end
        end
    end

    initial begin : watchdog
        #(clk_period * (prog_len * 2 + 100));
        report_error("timeout, not all expected stores appeared in time");
    end

endmodule

`default_nettype wire

/* tb.f */
logic/core_pkg.sv
logic/fetch.sv
logic/decode.sv
logic/regbank.sv
logic/execute.sv
logic/retire.sv
logic/rs5_core.sv
tb/core_assertions.sv
tb/tb_core.sv

/* Bender.yml */
package:
  name: rs5_core

sources:
  - logic/core_pkg.sv
  - logic/fetch.sv
  - logic/decode.sv
  - logic/regbank.sv
  - logic/execute.sv
  - logic/retire.sv
  - logic/rs5_core.sv
  - target: test
    files:
      - tb/core_assertions.sv
      - tb/tb_core.sv
